// File: flist.f
mgmt_core_pkg.sv
hk_bus_if.sv
hk_cfg_if.sv
hk_spi_slave.sv
hk_regs.sv
core_clocking.sv
mgmt_io_mux.sv
mgmt_core.sv
tb_mgmt_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the management core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mgmt_core -f flist.f -o sim_tb_mgmt_core

./obj_dir/sim_tb_mgmt_core 2>&1 | tee sim.log

if grep -q "^Test passed$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_mgmt_core.sv
// Directed testbench for the management core housekeeping SPI, pads and clocking
`timescale 1ns/1ps

module tb_mgmt_core;

	// Pads that the pad mux always drives
	localparam logic [15:0] DRIVEN_MASK = 16'hC003;
	// Flash select, SCK and IO0 pads taken over by pass-through
	localparam logic [15:0] FLASH_MASK = 16'h0700;

	logic clock = 1'b0;
	logic rst_n;
	logic [15:0] in_data;
	logic [31:0] mask_rev;
	logic [15:0] out_data;
	logic [15:0] oeb;
	logic sdo;
	logic sdo_outenb;
	logic core_rstn;
	logic user_clk;
	int unsigned cycles = 0;
	// Last values written to the pad registers
	logic [15:0] out_val;
	logic [15:0] oeb_val;

	mgmt_core dut_i (
		.clock_i         (clock),
		.rst_n_i         (rst_n),
		.mgmt_in_data_i  (in_data),
		.mask_rev_i      (mask_rev),
		.mgmt_out_data_o (out_data),
		.mgmt_oeb_o      (oeb),
		.sdo_o           (sdo),
		.sdo_outenb_o    (sdo_outenb),
		.core_rstn_o     (core_rstn),
		.user_clk_o      (user_clk)
	);

	always #50 clock = ~clock;

	// About 22 SPI frames of 140 cycles plus pass-through and clock checks
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == 4000) begin
			$display("timeout: the run did not finish within 4000 clock cycles");
			$display("Test failed");
			$fatal(1);
		end
	end

	// Returns 5 ns after the n-th rising edge
	task wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#5;
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// One full frame, command byte then data byte, 4 cycles per SCK phase
	task spi_xfer(input logic [7:0] cmd, input logic [7:0] wdat, output logic [7:0] rdat);
		logic [15:0] frame;
		logic rd_cmd;
		frame = {cmd, wdat};
		rd_cmd = (cmd[7:6] == mgmt_core_pkg::CMD_READ);
		rdat = '0;
		in_data[mgmt_core_pkg::CSB_PAD] = 1'b0;
		wait_cycles(4);
		for (int i = 15; i >= 0; i--) begin
			in_data[mgmt_core_pkg::SCK_PAD] = 1'b0;
			in_data[mgmt_core_pkg::SDI_PAD] = frame[i];
			wait_cycles(4);
			// SDO enabled only in the data phase of a read
			check_value("sdo_outenb_o", sdo_outenb, !(rd_cmd && i < 8));
			if (i < 8)
				rdat[i] = sdo;
			in_data[mgmt_core_pkg::SCK_PAD] = 1'b1;
			wait_cycles(4);
		end
		in_data[mgmt_core_pkg::SCK_PAD] = 1'b0;
		wait_cycles(4);
		in_data[mgmt_core_pkg::CSB_PAD] = 1'b1;
		wait_cycles(4);
	endtask

	task spi_write(input logic [5:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		spi_xfer({mgmt_core_pkg::CMD_WRITE, addr}, data, unused);
	endtask

	task spi_read(input logic [5:0] addr, output logic [7:0] data);
		spi_xfer({mgmt_core_pkg::CMD_READ, addr}, 8'h00, data);
	endtask

	// Pass command byte, CSB then stays low
	task spi_pass_begin;
		logic [7:0] cmd;
		cmd = {mgmt_core_pkg::CMD_PASS_USER, 6'h00};
		in_data[mgmt_core_pkg::CSB_PAD] = 1'b0;
		wait_cycles(4);
		for (int i = 7; i >= 0; i--) begin
			in_data[mgmt_core_pkg::SCK_PAD] = 1'b0;
			in_data[mgmt_core_pkg::SDI_PAD] = cmd[i];
			wait_cycles(4);
			in_data[mgmt_core_pkg::SCK_PAD] = 1'b1;
			wait_cycles(4);
		end
		in_data[mgmt_core_pkg::SCK_PAD] = 1'b0;
		wait_cycles(4);
	endtask

	task spi_pass_end;
		in_data[mgmt_core_pkg::SCK_PAD] = 1'b0;
		in_data[mgmt_core_pkg::CSB_PAD] = 1'b1;
		wait_cycles(4);
	endtask

	task test_reset;
		wait_cycles(5);
		check_value("core_rstn_o", core_rstn, 1'b0);
		check_value("mgmt_oeb_o", oeb, 16'hFFFF & ~DRIVEN_MASK);
		check_value("sdo_outenb_o", sdo_outenb, 1'b1);
		check_value("user_clk_o", user_clk, 1'b0);
		rst_n = 1'b1;
		// Core reset releases on the second edge
		wait_cycles(1);
		check_value("core_rstn_o", core_rstn, 1'b0);
		wait_cycles(1);
		check_value("core_rstn_o", core_rstn, 1'b1);
	endtask

	task test_mask_rev;
		logic [7:0] rd;
		for (int i = 0; i < 4; i++) begin
			spi_read(6'(int'(mgmt_core_pkg::REG_MASK_REV0) + i), rd);
			check_value($sformatf("mask rev byte %0d", i), rd, mask_rev[8*i +: 8]);
		end
		// Unmapped
		spi_read(6'h20, rd);
		check_value("unmapped read", rd, 8'h00);
		// Mask revision is read only, config stays at its reset values
		spi_write(mgmt_core_pkg::REG_MASK_REV0, 8'hFF);
		check_value("mgmt_out_data_o", out_data, 16'h0000);
		check_value("mgmt_oeb_o", oeb, 16'hFFFF & ~DRIVEN_MASK);
		check_value("core_rstn_o", core_rstn, 1'b1);
		check_value("user_clk_o", user_clk, 1'b0);
	endtask

	task test_pad_regs;
		logic [7:0] rd;
		out_val = 16'($urandom);
		oeb_val = 16'($urandom);
		spi_write(mgmt_core_pkg::REG_IO_OUT_LO, out_val[7:0]);
		spi_write(mgmt_core_pkg::REG_IO_OUT_HI, out_val[15:8]);
		spi_write(mgmt_core_pkg::REG_IO_OEB_LO, oeb_val[7:0]);
		spi_write(mgmt_core_pkg::REG_IO_OEB_HI, oeb_val[15:8]);
		check_value("mgmt_out_data_o", out_data, out_val);
		check_value("mgmt_oeb_o", oeb, oeb_val & ~DRIVEN_MASK);
		spi_read(mgmt_core_pkg::REG_IO_OUT_LO, rd);
		check_value("io out lo", rd, out_val[7:0]);
		spi_read(mgmt_core_pkg::REG_IO_OUT_HI, rd);
		check_value("io out hi", rd, out_val[15:8]);
		spi_read(mgmt_core_pkg::REG_IO_OEB_LO, rd);
		check_value("io oeb lo", rd, oeb_val[7:0]);
		spi_read(mgmt_core_pkg::REG_IO_OEB_HI, rd);
		check_value("io oeb hi", rd, oeb_val[15:8]);
	endtask

	task test_clocking;
		int n_high;
		int n_low;
		logic [7:0] rd;
		spi_write(mgmt_core_pkg::REG_CLK_CTRL, 8'h03);
		// Line up on a rising user clock
		while (user_clk)
			wait_cycles(1);
		while (!user_clk)
			wait_cycles(1);
		n_high = 0;
		n_low = 0;
		while (user_clk) begin
			n_high++;
			wait_cycles(1);
		end
		while (!user_clk) begin
			n_low++;
			wait_cycles(1);
		end
		check_value("user_clk_o high cycles", n_high, 3);
		check_value("user_clk_o low cycles", n_low, 3);
		// External reset bit holds the core
		spi_write(mgmt_core_pkg::REG_CLK_CTRL, 8'h13);
		check_value("core_rstn_o", core_rstn, 1'b0);
		spi_read(mgmt_core_pkg::REG_CLK_CTRL, rd);
		check_value("clk ctrl", rd, 8'h13);
		check_value("core_rstn_o", core_rstn, 1'b0);
		spi_write(mgmt_core_pkg::REG_CLK_CTRL, 8'h03);
		check_value("core_rstn_o", core_rstn, 1'b1);
		// Divide of zero parks the clock low
		spi_write(mgmt_core_pkg::REG_CLK_CTRL, 8'h00);
		repeat (8) begin
			check_value("user_clk_o", user_clk, 1'b0);
			wait_cycles(1);
		end
	endtask

	task test_pass_through;
		logic sck_v;
		logic sdi_v;
		logic io1_v;
		logic [15:0] exp_out;
		spi_pass_begin;
		repeat (6) begin
			sck_v = 1'($urandom);
			sdi_v = 1'($urandom);
			io1_v = 1'($urandom);
			in_data[mgmt_core_pkg::SCK_PAD] = sck_v;
			in_data[mgmt_core_pkg::SDI_PAD] = sdi_v;
			in_data[mgmt_core_pkg::FLASH_IO1_PAD] = io1_v;
			wait_cycles(4);
			exp_out = out_val;
			exp_out[mgmt_core_pkg::FLASH_CSB_PAD] = 1'b0;
			exp_out[mgmt_core_pkg::FLASH_SCK_PAD] = sck_v;
			exp_out[mgmt_core_pkg::FLASH_IO0_PAD] = sdi_v;
			check_value("mgmt_out_data_o", out_data, exp_out);
			check_value("mgmt_oeb_o", oeb, oeb_val & ~DRIVEN_MASK & ~FLASH_MASK);
			check_value("sdo_o", sdo, io1_v);
		end
		spi_pass_end;
		// Flash IO1 high, so SDO low can only come from the idle slave
		in_data[mgmt_core_pkg::FLASH_IO1_PAD] = 1'b1;
		// Register values again once CSB is up
		check_value("mgmt_out_data_o", out_data, out_val);
		check_value("mgmt_oeb_o", oeb, oeb_val & ~DRIVEN_MASK);
		check_value("sdo_o", sdo, 1'b0);
	endtask

	task test_sdo_override;
		out_val[mgmt_core_pkg::SDO_PAD] = 1'b1;
		spi_write(mgmt_core_pkg::REG_IO_OUT_LO, out_val[7:0]);
		spi_write(mgmt_core_pkg::REG_SDO_CTRL, 8'h01);
		check_value("sdo_o", sdo, 1'b1);
		spi_write(mgmt_core_pkg::REG_SDO_CTRL, 8'h00);
		// Idle slave drives SDO low
		check_value("sdo_o", sdo, 1'b0);
		check_value("sdo_outenb_o", sdo_outenb, 1'b1);
	endtask

	initial begin
		rst_n = 1'b0;
		in_data = '0;
		in_data[mgmt_core_pkg::CSB_PAD] = 1'b1;
		void'($urandom(32'h48ae));
		mask_rev = $urandom;
		test_reset();
		test_mask_rev();
		test_pad_regs();
		test_clocking();
		test_pass_through();
		test_sdo_override();
		$display("Test passed");
		$finish;
	end

endmodule

// File: mgmt_core.sv
// Management core housekeeping top with SPI slave, registers, clocking and pad mux
`timescale 1ns/1ps

module mgmt_core (
	input  logic clock_i,
	input  logic rst_n_i,
	input  logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	input  logic [31:0] mask_rev_i,
	output logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_o,
	output logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_oeb_o,
	output logic sdo_o,
	output logic sdo_outenb_o,
	output logic core_rstn_o,
	output logic user_clk_o
);

	logic spi_sdo;
	logic pass_thru_user;

	hk_bus_if bus_if ();
	hk_cfg_if cfg_if ();

	// Housekeeping SPI listens on pads 2 to 4
	hk_spi_slave spi_i (
		.clock_i          (clock_i),
		.rst_n_i          (rst_n_i),
		.spi_csb_i        (mgmt_in_data_i[mgmt_core_pkg::CSB_PAD]),
		.spi_sck_i        (mgmt_in_data_i[mgmt_core_pkg::SCK_PAD]),
		.spi_sdi_i        (mgmt_in_data_i[mgmt_core_pkg::SDI_PAD]),
		.spi_sdo_o        (spi_sdo),
		.sdo_outenb_o     (sdo_outenb_o),
		.pass_thru_user_o (pass_thru_user),
		.bus              (bus_if.slave_mp)
	);

	hk_regs regs_i (
		.clock_i    (clock_i),
		.rst_n_i    (rst_n_i),
		.mask_rev_i (mask_rev_i),
		.bus        (bus_if.regs_mp),
		.cfg        (cfg_if.regs_mp)
	);

	// Stands in for the PLL and reset tree
	core_clocking clocking_i (
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.cfg         (cfg_if.clk_mp),
		.core_rstn_o (core_rstn_o),
		.user_clk_o  (user_clk_o)
	);

	mgmt_io_mux io_mux_i (
		.cfg              (cfg_if.io_mp),
		.pass_thru_user_i (pass_thru_user),
		.spi_sdo_i        (spi_sdo),
		.mgmt_in_data_i   (mgmt_in_data_i),
		.mgmt_out_data_o  (mgmt_out_data_o),
		.mgmt_oeb_o       (mgmt_oeb_o),
		.sdo_o            (sdo_o)
	);

	// Flash chip select stays driven low for as long as the slave holds pass-through
	a_flash_csb_low: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		pass_thru_user |->
		!mgmt_out_data_o[mgmt_core_pkg::FLASH_CSB_PAD] &&
		!mgmt_oeb_o[mgmt_core_pkg::FLASH_CSB_PAD]);

endmodule

// File: mgmt_io_mux.sv
// Management pad data and enable mux with user flash pass-through and SDO override
`timescale 1ns/1ps

module mgmt_io_mux (
	hk_cfg_if.io_mp cfg,
	input  logic    pass_thru_user_i,
	input  logic    spi_sdo_i,
	input  logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_in_data_i,
	output logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_out_data_o,
	output logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] mgmt_oeb_o,
	output logic    sdo_o
);

	always_comb begin
		// Register values by default
		mgmt_out_data_o = cfg.io_out;
		// Edge pads have no input path so they stay driven
		mgmt_oeb_o = cfg.io_oeb & ~mgmt_core_pkg::ALWAYS_DRV_MASK;

		// Override hands the SDO pad to io_out
		if (cfg.sdo_override)
			sdo_o = cfg.io_out[mgmt_core_pkg::SDO_PAD];
		else
			sdo_o = spi_sdo_i;

		// Flash pass-through takes over pads 8 to 10
		if (pass_thru_user_i) begin
			// Flash select held low for the whole transfer
			mgmt_out_data_o[mgmt_core_pkg::FLASH_CSB_PAD] = 1'b0;
			// Host SCK and SDI go straight to the flash
			mgmt_out_data_o[mgmt_core_pkg::FLASH_SCK_PAD] =
				mgmt_in_data_i[mgmt_core_pkg::SCK_PAD];
			mgmt_out_data_o[mgmt_core_pkg::FLASH_IO0_PAD] =
				mgmt_in_data_i[mgmt_core_pkg::SDI_PAD];
			mgmt_oeb_o[mgmt_core_pkg::FLASH_CSB_PAD] = 1'b0;
			mgmt_oeb_o[mgmt_core_pkg::FLASH_SCK_PAD] = 1'b0;
			mgmt_oeb_o[mgmt_core_pkg::FLASH_IO0_PAD] = 1'b0;
			// Flash data out returns to the host on SDO
			sdo_o = mgmt_in_data_i[mgmt_core_pkg::FLASH_IO1_PAD];
		end
	end

endmodule

// File: core_clocking.sv
// Core reset synchronizer with external reset hold, and the divided user clock
`timescale 1ns/1ps

module core_clocking (
	input  logic      clock_i,
	input  logic      rst_n_i,
	hk_cfg_if.clk_mp  cfg,
	output logic      core_rstn_o,
	output logic      user_clk_o
);

	logic [1:0] rstn_sync;
	logic [mgmt_core_pkg::USER_DIV_W-1:0] div_cnt;
	logic [mgmt_core_pkg::USER_DIV_W-1:0] div_last;

	// Two stage release, either source pulls it low at once
	always_ff @(posedge clock_i) begin
		if (!rst_n_i || cfg.ext_reset)
			rstn_sync <= 2'b00;
		else
			rstn_sync <= {rstn_sync[0], 1'b1};
	end

	assign core_rstn_o = rstn_sync[1];

	// Last count before a toggle
	assign div_last = cfg.user_div - 1'b1;

	// Toggle every user_div cycles, divide of zero parks the clock low
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			div_cnt <= '0;
			user_clk_o <= 1'b0;
		end else if (cfg.user_div == '0) begin
			div_cnt <= '0;
			user_clk_o <= 1'b0;
		end else if (div_cnt >= div_last) begin
			// Also catches a divide lowered mid count
			div_cnt <= '0;
			user_clk_o <= !user_clk_o;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Register bit set by SPI must hold the core in reset from the next cycle
	a_ext_reset_hold: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		cfg.ext_reset |=> !core_rstn_o);

endmodule

// File: hk_regs.sv
// Housekeeping register bank with mask revision readback and configuration outputs
`timescale 1ns/1ps

module hk_regs (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic [31:0] mask_rev_i,
	hk_bus_if.regs_mp   bus,
	hk_cfg_if.regs_mp   cfg
);

	logic [mgmt_core_pkg::USER_DIV_W-1:0] user_div_q;
	logic ext_reset_q;
	logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] io_out_q;
	logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] io_oeb_q;
	logic sdo_ovr_q;
	logic ro_addr;

	// Register writes, unmapped and read-only addresses fall through
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			user_div_q <= '0;
			ext_reset_q <= 1'b0;
			io_out_q <= '0;
			io_oeb_q <= mgmt_core_pkg::OEB_RESET;
			sdo_ovr_q <= 1'b0;
		end else if (bus.wr_en) begin
			case (bus.addr)
				mgmt_core_pkg::REG_CLK_CTRL: begin
					user_div_q <= bus.wdata[mgmt_core_pkg::USER_DIV_W-1:0];
					ext_reset_q <= bus.wdata[mgmt_core_pkg::CLK_EXT_RESET_BIT];
				end
				mgmt_core_pkg::REG_IO_OUT_LO: io_out_q[7:0] <= bus.wdata;
				mgmt_core_pkg::REG_IO_OUT_HI: io_out_q[15:8] <= bus.wdata;
				mgmt_core_pkg::REG_IO_OEB_LO: io_oeb_q[7:0] <= bus.wdata;
				mgmt_core_pkg::REG_IO_OEB_HI: io_oeb_q[15:8] <= bus.wdata;
				mgmt_core_pkg::REG_SDO_CTRL: sdo_ovr_q <= bus.wdata[0];
				default: ;
			endcase
		end
	end

	// Read decode, valid in the rd_en cycle
	always_comb begin
		bus.rdata = '0;
		case (bus.addr)
			mgmt_core_pkg::REG_MASK_REV0: bus.rdata = mask_rev_i[7:0];
			mgmt_core_pkg::REG_MASK_REV1: bus.rdata = mask_rev_i[15:8];
			mgmt_core_pkg::REG_MASK_REV2: bus.rdata = mask_rev_i[23:16];
			mgmt_core_pkg::REG_MASK_REV3: bus.rdata = mask_rev_i[31:24];
			mgmt_core_pkg::REG_CLK_CTRL: begin
				bus.rdata[mgmt_core_pkg::USER_DIV_W-1:0] = user_div_q;
				bus.rdata[mgmt_core_pkg::CLK_EXT_RESET_BIT] = ext_reset_q;
			end
			mgmt_core_pkg::REG_IO_OUT_LO: bus.rdata = io_out_q[7:0];
			mgmt_core_pkg::REG_IO_OUT_HI: bus.rdata = io_out_q[15:8];
			mgmt_core_pkg::REG_IO_OEB_LO: bus.rdata = io_oeb_q[7:0];
			mgmt_core_pkg::REG_IO_OEB_HI: bus.rdata = io_oeb_q[15:8];
			mgmt_core_pkg::REG_SDO_CTRL: bus.rdata[0] = sdo_ovr_q;
			default: ;
		endcase
	end

	assign cfg.user_div = user_div_q;
	assign cfg.ext_reset = ext_reset_q;
	assign cfg.io_out = io_out_q;
	assign cfg.io_oeb = io_oeb_q;
	assign cfg.sdo_override = sdo_ovr_q;

	// Mask revision window
	assign ro_addr = (bus.addr >= mgmt_core_pkg::REG_MASK_REV0) &&
		(bus.addr <= mgmt_core_pkg::REG_MASK_REV3);

	// A write to the mask revision leaves every config field unchanged
	a_ro_write: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(bus.wr_en && ro_addr) |=>
		$stable({user_div_q, ext_reset_q, io_out_q, io_oeb_q, sdo_ovr_q}));

endmodule

// File: hk_spi_slave.sv
// Housekeeping SPI slave oversampled on the core clock, decodes commands into bus accesses
`timescale 1ns/1ps

module hk_spi_slave (
	input  logic       clock_i,
	input  logic       rst_n_i,
	input  logic       spi_csb_i,
	input  logic       spi_sck_i,
	input  logic       spi_sdi_i,
	output logic       spi_sdo_o,
	output logic       sdo_outenb_o,
	output logic       pass_thru_user_o,
	hk_bus_if.slave_mp bus
);

	logic [1:0] csb_sync;
	logic [1:0] sck_sync;
	logic [1:0] sdi_sync;
	logic sck_prev;
	logic csb_high;
	logic sck_rise;
	logic sck_fall;
	logic [4:0] bit_cnt;
	logic [1:0] cmd_code;
	logic wr_en_q;
	logic rd_en_q;
	logic [mgmt_core_pkg::HK_DATA_W-2:0] shift_in;
	logic [mgmt_core_pkg::HK_DATA_W-1:0] byte_in;
	logic [mgmt_core_pkg::HK_DATA_W-1:0] shift_out;
	logic [mgmt_core_pkg::HK_ADDR_W-1:0] addr_q;
	logic [mgmt_core_pkg::HK_DATA_W-1:0] wdata_q;

	// Two flop synchronizers, CSB idles high
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			csb_sync <= 2'b11;
			sck_sync <= 2'b00;
			sck_prev <= 1'b0;
		end else begin
			csb_sync <= {csb_sync[0], spi_csb_i};
			sck_sync <= {sck_sync[0], spi_sck_i};
			sck_prev <= sck_sync[1];
		end
	end

	assign csb_high = csb_sync[1];
	// Edges only count inside a transaction
	assign sck_rise = !csb_high && sck_sync[1] && !sck_prev;
	assign sck_fall = !csb_high && !sck_sync[1] && sck_prev;
	// Byte completed by the bit arriving now
	assign byte_in = {shift_in, sdi_sync[1]};

	// Bit counter and command decode, CSB high aborts everything
	always_ff @(posedge clock_i) begin
		if (!rst_n_i || csb_high) begin
			bit_cnt <= '0;
			cmd_code <= '0;
			wr_en_q <= 1'b0;
			rd_en_q <= 1'b0;
			sdo_outenb_o <= 1'b1;
			spi_sdo_o <= 1'b0;
			pass_thru_user_o <= 1'b0;
		end else begin
			wr_en_q <= 1'b0;
			rd_en_q <= 1'b0;
			// Stop after the data byte, extra clocks are ignored
			if (sck_rise && bit_cnt != 5'(2 * mgmt_core_pkg::HK_DATA_W)) begin
				bit_cnt <= bit_cnt + 5'd1;
				// Eighth bit closes the command byte
				if (bit_cnt == 5'(mgmt_core_pkg::HK_DATA_W - 1)) begin
					cmd_code <= byte_in[mgmt_core_pkg::HK_DATA_W-1 -: 2];
					rd_en_q <= (byte_in[mgmt_core_pkg::HK_DATA_W-1 -: 2] ==
						mgmt_core_pkg::CMD_READ);
					pass_thru_user_o <= (byte_in[mgmt_core_pkg::HK_DATA_W-1 -: 2] ==
						mgmt_core_pkg::CMD_PASS_USER);
				end
				// Sixteenth bit closes the data byte
				if (bit_cnt == 5'(2 * mgmt_core_pkg::HK_DATA_W - 1))
					wr_en_q <= (cmd_code == mgmt_core_pkg::CMD_WRITE);
			end
			// Drive SDO for the rest of a read
			if (rd_en_q)
				sdo_outenb_o <= 1'b0;
			// Read data leaves MSB first on falling SCK
			if (sck_fall && !sdo_outenb_o)
				spi_sdo_o <= shift_out[mgmt_core_pkg::HK_DATA_W-1];
		end
	end

	// Shift registers and captured address and data
	always_ff @(posedge clock_i) begin
		sdi_sync <= {sdi_sync[0], spi_sdi_i};
		if (sck_rise)
			shift_in <= byte_in[mgmt_core_pkg::HK_DATA_W-2:0];
		if (sck_rise && bit_cnt == 5'(mgmt_core_pkg::HK_DATA_W - 1))
			addr_q <= byte_in[mgmt_core_pkg::HK_ADDR_W-1:0];
		if (sck_rise && bit_cnt == 5'(2 * mgmt_core_pkg::HK_DATA_W - 1))
			wdata_q <= byte_in;
		// Load while rdata is valid, then shift with each SDO bit
		if (rd_en_q)
			shift_out <= bus.rdata;
		else if (sck_fall && !sdo_outenb_o)
			shift_out <= {shift_out[mgmt_core_pkg::HK_DATA_W-2:0], 1'b0};
	end

	assign bus.wr_en = wr_en_q;
	assign bus.rd_en = rd_en_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	// Read and write strobes come from different command codes
	a_rd_wr_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(bus.wr_en && bus.rd_en));

	// Host timing keeps every access inside the CSB low window
	a_no_access_idle: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(bus.wr_en || bus.rd_en) |-> !csb_high);

endmodule

// File: hk_cfg_if.sv
// Housekeeping configuration fields fanned out to the clocking and pad blocks
`timescale 1ns/1ps

interface hk_cfg_if;

	// User clock divide value, zero stops the clock
	logic [mgmt_core_pkg::USER_DIV_W-1:0] user_div;

	// Holds the core in reset while set
	logic ext_reset;

	// Pad output data and output enable bar
	logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] io_out;
	logic [mgmt_core_pkg::MPRJ_IO_PADS-1:0] io_oeb;

	// SDO pad driven from io_out instead of the SPI slave
	logic sdo_override;

	modport regs_mp (
		output user_div,
		output ext_reset,
		output io_out,
		output io_oeb,
		output sdo_override
	);

	modport clk_mp (
		input user_div,
		input ext_reset
	);

	modport io_mp (
		input io_out,
		input io_oeb,
		input sdo_override
	);

endinterface

// File: hk_bus_if.sv
// Housekeeping register access bus between the SPI slave and the register bank
`timescale 1ns/1ps

interface hk_bus_if;

	// Single cycle strobes, never both high
	logic wr_en;
	logic rd_en;
	logic [mgmt_core_pkg::HK_ADDR_W-1:0] addr;
	logic [mgmt_core_pkg::HK_DATA_W-1:0] wdata;
	// Combinational from addr
	logic [mgmt_core_pkg::HK_DATA_W-1:0] rdata;

	modport slave_mp (output wr_en, output rd_en, output addr, output wdata, input rdata);

	modport regs_mp (input wr_en, input rd_en, input addr, input wdata, output rdata);

endinterface

// File: mgmt_core_pkg.sv
// Management core constants for pad indices, housekeeping register map and SPI commands
package mgmt_core_pkg;

	// Pad count and housekeeping bus widths
	localparam int MPRJ_IO_PADS = 16;
	localparam int HK_ADDR_W = 6;
	localparam int HK_DATA_W = 8;
	localparam int USER_DIV_W = 4;

	// Command codes sit in the top two bits of the command byte
	// Code 00 is a no-op
	localparam logic [1:0] CMD_WRITE = 2'b10;
	localparam logic [1:0] CMD_READ = 2'b01;
	localparam logic [1:0] CMD_PASS_USER = 2'b11;

	// Mask revision bytes, least significant first, read only
	localparam logic [HK_ADDR_W-1:0] REG_MASK_REV0 = 6'h01;
	localparam logic [HK_ADDR_W-1:0] REG_MASK_REV1 = 6'h02;
	localparam logic [HK_ADDR_W-1:0] REG_MASK_REV2 = 6'h03;
	localparam logic [HK_ADDR_W-1:0] REG_MASK_REV3 = 6'h04;

	// User clock divide in bits 3:0, external reset in bit 4
	localparam logic [HK_ADDR_W-1:0] REG_CLK_CTRL = 6'h08;
	localparam int CLK_EXT_RESET_BIT = 4;

	// Pad output data and output enable bar, split in bytes
	localparam logic [HK_ADDR_W-1:0] REG_IO_OUT_LO = 6'h0A;
	localparam logic [HK_ADDR_W-1:0] REG_IO_OUT_HI = 6'h0B;
	localparam logic [HK_ADDR_W-1:0] REG_IO_OEB_LO = 6'h0C;
	localparam logic [HK_ADDR_W-1:0] REG_IO_OEB_HI = 6'h0D;

	// SDO override in bit 0
	localparam logic [HK_ADDR_W-1:0] REG_SDO_CTRL = 6'h0E;

	// All pads start as inputs
	localparam logic [MPRJ_IO_PADS-1:0] OEB_RESET = 16'hFFFF;

	// Pads 0, 1, 14 and 15 have no input path and are always driven
	localparam logic [MPRJ_IO_PADS-1:0] ALWAYS_DRV_MASK = 16'hC003;

	// Housekeeping SPI pads
	localparam int SDO_PAD = 1;
	localparam int SDI_PAD = 2;
	localparam int CSB_PAD = 3;
	localparam int SCK_PAD = 4;

	// User flash pass-through pads
	localparam int FLASH_CSB_PAD = 8;
	localparam int FLASH_SCK_PAD = 9;
	localparam int FLASH_IO0_PAD = 10;
	localparam int FLASH_IO1_PAD = 11;

endpackage
